// File: compile.f
+incdir+common
common/msx_bus_pkg.sv
common/msx_dev_pkg.sv
common/msx_bus_if.sv
hw/bus_arbiter.sv
ppi/key_matrix.sv
ppi/ppi.sv
hw/msx_io_top.sv
dv/tb_msx_io.sv

// File: Bender.yml
package:
  name: msx_io

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/msx_bus_pkg.sv
      - common/msx_dev_pkg.sv
      - common/msx_bus_if.sv
      - hw/bus_arbiter.sv
      - ppi/key_matrix.sv
      - ppi/ppi.sv
      - hw/msx_io_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_msx_io.sv

// File: dv/tb_msx_io.sv
// inputs change on the falling edge; the model assumes the PPI at MSX_PPI_BASE and no memory device
`include "msx_bus_defs.svh"

module tb_msx_io;
	timeunit 1ns;
	timeprecision 100ps;

	import msx_bus_pkg::*;

	localparam logic [7:0] ppi_base   = `MSX_PPI_BASE;
	localparam int         done_limit = 20;

	logic        clk;
	logic        n_reset;
	// cpu master
	logic        cpu_req;
	bus_op_e     cpu_op;
	logic [15:0] cpu_address;
	logic [7:0]  cpu_write_data;
	logic        cpu_done;
	logic [7:0]  cpu_read_data;
	// debug master
	logic        dbg_req;
	bus_op_e     dbg_op;
	logic [15:0] dbg_address;
	logic [7:0]  dbg_write_data;
	logic        dbg_done;
	logic [7:0]  dbg_read_data;
	// key events
	logic        key_valid;
	logic [3:0]  key_event_row;
	logic [2:0]  key_col;
	logic        key_pressed;
	// PPI outputs
	logic [7:0]  primary_slot;
	logic [3:0]  key_row;
	logic        motor_off;
	logic        cas_write;
	logic        caps_led_off;
	logic        click_sound;
	logic [7:0]  port_c_out;

	// reference model of port A, port C and the key rows (rows 11 to 15 stay FFh)
	logic [7:0]       model_slot;
	logic [7:0]       model_port_c;
	logic [15:0][7:0] model_keys;

	// check windows
	logic reset_quiet;
	logic cpu_first;
	logic timed;
	logic slow_read;
	// other master's completions seen while a request waits
	int   cpu_wait_cnt;
	int   dbg_wait_cnt;

	msx_io_top dut_i (
		.clk (clk), .n_reset (n_reset),
		.cpu_req (cpu_req), .cpu_op (cpu_op), .cpu_address (cpu_address),
		.cpu_write_data (cpu_write_data), .cpu_done (cpu_done), .cpu_read_data (cpu_read_data),
		.dbg_req (dbg_req), .dbg_op (dbg_op), .dbg_address (dbg_address),
		.dbg_write_data (dbg_write_data), .dbg_done (dbg_done), .dbg_read_data (dbg_read_data),
		.key_valid (key_valid), .key_event_row (key_event_row), .key_col (key_col),
		.key_pressed (key_pressed), .primary_slot (primary_slot), .key_row (key_row),
		.motor_off (motor_off), .cas_write (cas_write), .caps_led_off (caps_led_off),
		.click_sound (click_sound)
	);

	// port C layout with the top bit first
	assign port_c_out = {click_sound, caps_led_off, cas_write, motor_off, key_row};

	always #2 clk = ~clk;

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic logic [15:0] port_addr(input logic [1:0] idx);
		return {8'h00, ppi_base[7:2], idx};
	endfunction

	function automatic bit is_read(input bus_op_e op);
		return (op == op_io_read) || (op == op_mem_read);
	endfunction

	// io cycles on A8h to ABh decoded from the low address byte
	function automatic bit ppi_hit(input bus_op_e op, input logic [15:0] address);
		return ((op == op_io_read) || (op == op_io_write)) && (address[7:2] == ppi_base[7:2]);
	endfunction

	// unanswered reads and port D float high
	function automatic logic [7:0] expected_read(input bus_op_e op, input logic [15:0] address,
			input logic [7:0] slot, input logic [7:0] port_c, input logic [15:0][7:0] keys);
		if (!ppi_hit(op, address)) begin
			return 8'hFF;
		end
		case (address[1:0])
			2'd0:    return slot;
			2'd1:    return keys[port_c[3:0]];
			2'd2:    return port_c;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic apply_write(input bus_op_e op, input logic [15:0] address,
			input logic [7:0] data);
		if (op == op_io_write && ppi_hit(op, address)) begin
			if (address[1:0] == 2'd0) begin
				model_slot = data;
			end else if (address[1:0] == 2'd2) begin
				model_port_c = data;
			end
		end
	endtask

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	// ----------------------------------------------------------
	// drivers
	// ----------------------------------------------------------
	// req stays up through done and drops in the next cycle unless the next request follows
	task automatic run_request(input bit use_dbg, input bus_op_e op,
			input logic [15:0] address, input logic [7:0] data, input bit hold = 1'b0);
		int cycles;
		bit seen;
		@(negedge clk);
		if (use_dbg) begin
			dbg_op         = op;
			dbg_address    = address;
			dbg_write_data = data;
			dbg_req        = 1'b1;
		end else begin
			slow_read      = is_read(op) && !ppi_hit(op, address);
			cpu_op         = op;
			cpu_address    = address;
			cpu_write_data = data;
			cpu_req        = 1'b1;
		end
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < done_limit) begin
			@(negedge clk);
			cycles++;
			seen = use_dbg ? dbg_done : cpu_done;
		end
		if (!seen) begin
			report_failure($sformatf("%s request at %0d ns: done never came within %0d cycles",
				use_dbg ? "debug" : "cpu", $time, done_limit));
		end
		apply_write(op, address, data);
		if (!hold) begin
			@(negedge clk);
			if (use_dbg) begin
				dbg_req = 1'b0;
			end else begin
				cpu_req = 1'b0;
			end
		end
	endtask

	// event reaches the matrix at the next rising edge
	task automatic send_key(input logic [3:0] row, input logic [2:0] col, input logic pressed);
		@(negedge clk);
		key_valid     = 1'b1;
		key_event_row = row;
		key_col       = col;
		key_pressed   = pressed;
		if (row < `MSX_KEY_ROWS) begin
			model_keys[row][col] = !pressed;
		end
		@(negedge clk);
		key_valid = 1'b0;
	endtask

	// mixed ports with port B never written
	task automatic random_requests(input bit use_dbg, input int count);
		bus_op_e     op;
		logic [15:0] address;
		int          pick;
		bit          hold;
		hold = 1'b0;
		for (int i = 0; i < count; i++) begin
			pick    = $urandom_range(0, 9);
			op      = bus_op_e'($urandom_range(0, 3));
			address = port_addr(2'(pick));
			if (pick >= 8) begin
				address = {8'h00, 8'($urandom_range(0, 8'hA7))};
			end
			if (op == op_io_write && address[7:0] == port_addr(2'd1)) begin
				address = port_addr(2'd2);
			end
			if (!hold) begin
				repeat ($urandom_range(0, 3)) @(negedge clk);
			end
			// about half the requests are followed at once by the next one
			hold = (i < count - 1) && ($urandom_range(0, 1) == 1);
			run_request(use_dbg, op, address, 8'($urandom), hold);
		end
	endtask

	// ----------------------------------------------------------
	// fairness counters
	// ----------------------------------------------------------
	always @(posedge clk) begin
		if (!n_reset || !cpu_req || cpu_done) begin
			cpu_wait_cnt <= 0;
		end else if (dbg_done) begin
			cpu_wait_cnt <= cpu_wait_cnt + 1;
		end
		if (!n_reset || !dbg_req || dbg_done) begin
			dbg_wait_cnt <= 0;
		end else if (cpu_done) begin
			dbg_wait_cnt <= dbg_wait_cnt + 1;
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_reset_values: assert property (@(posedge clk) disable iff (!n_reset)
		reset_quiet |-> primary_slot == 8'h00 && port_c_out == 8'h7F && !cpu_done && !dbg_done)
		else report_failure($sformatf("CHECK FAILED at %0d ns: reset values or idle done", $time));

	// outputs follow the model once a write completes
	a_outputs_model: assert property (@(posedge clk) disable iff (!n_reset)
		primary_slot == model_slot && port_c_out == model_port_c)
		else report_failure($sformatf("CHECK FAILED at %0d ns: slot %h port C %h differ from model",
			$time, $sampled(primary_slot), $sampled(port_c_out)));

	a_cpu_first: assert property (@(posedge clk) disable iff (!n_reset) cpu_first |-> !dbg_done)
		else report_failure($sformatf("CHECK FAILED at %0d ns: debug served before cpu", $time));

	a_cpu_data: assert property (@(posedge clk) disable iff (!n_reset)
		cpu_done && is_read(cpu_op) |-> cpu_read_data ==
		expected_read(cpu_op, cpu_address, model_slot, model_port_c, model_keys))
		else report_failure($sformatf("CHECK FAILED at %0d ns: cpu read %h from %h is wrong",
			$time, $sampled(cpu_read_data), $sampled(cpu_address)));

	a_dbg_data: assert property (@(posedge clk) disable iff (!n_reset)
		dbg_done && is_read(dbg_op) |-> dbg_read_data ==
		expected_read(dbg_op, dbg_address, model_slot, model_port_c, model_keys))
		else report_failure($sformatf("CHECK FAILED at %0d ns: debug read %h from %h is wrong",
			$time, $sampled(dbg_read_data), $sampled(dbg_address)));

	// PPI accesses and all writes end two cycles after the request is sampled
	a_cpu_fast: assert property (@(posedge clk) disable iff (!n_reset)
		$rose(cpu_req) && timed && !slow_read |-> !cpu_done ##1 !cpu_done ##1 cpu_done)
		else report_failure($sformatf("CHECK FAILED at %0d ns: cpu done not after 2 cycles", $time));

	a_cpu_slow: assert property (@(posedge clk) disable iff (!n_reset)
		$rose(cpu_req) && timed && slow_read |->
		!cpu_done [*(`MSX_BUS_READ_WAIT + 1)] ##1 cpu_done)
		else report_failure($sformatf("CHECK FAILED at %0d ns: unanswered read timing", $time));

	a_done_with_req: assert property (@(posedge clk) disable iff (!n_reset)
		(!cpu_done || cpu_req) && (!dbg_done || dbg_req))
		else report_failure($sformatf("CHECK FAILED at %0d ns: done without a request", $time));

	a_done_once: assert property (@(posedge clk) disable iff (!n_reset)
		!(cpu_done && $past(cpu_done)) && !(dbg_done && $past(dbg_done)))
		else report_failure($sformatf("CHECK FAILED at %0d ns: request completed twice", $time));

	a_alternate: assert property (@(posedge clk) disable iff (!n_reset)
		cpu_wait_cnt < 2 && dbg_wait_cnt < 2)
		else report_failure($sformatf("CHECK FAILED at %0d ns: grants did not alternate", $time));

	// ----------------------------------------------------------
	// sequences
	// ----------------------------------------------------------
	initial begin
		logic [15:0] address;
		logic [7:0]  data;
		void'($urandom(32'h20cd3a1f));
		clk            = 1'b0;
		n_reset        = 1'b0;
		cpu_req        = 1'b0;
		cpu_op         = op_io_read;
		cpu_address    = '0;
		cpu_write_data = '0;
		dbg_req        = 1'b0;
		dbg_op         = op_io_read;
		dbg_address    = '0;
		dbg_write_data = '0;
		key_valid      = 1'b0;
		key_event_row  = '0;
		key_col        = '0;
		key_pressed    = 1'b0;
		model_slot     = 8'h00;
		model_port_c   = 8'h7F;
		model_keys     = '1;
		reset_quiet    = 1'b0;
		cpu_first      = 1'b0;
		timed          = 1'b0;
		slow_read      = 1'b0;
		repeat (8) @(negedge clk);
		n_reset     = 1'b1;
		reset_quiet = 1'b1;
		repeat (4) @(negedge clk);
		reset_quiet = 1'b0;

		// both ask at once and the cpu has priority after reset
		cpu_first = 1'b1;
		fork
			begin
				run_request(1'b0, op_io_read, port_addr(2'd0), 8'h00);
				cpu_first = 1'b0;
			end
			run_request(1'b1, op_io_read, port_addr(2'd2), 8'h00);
		join

		// port A and port C write and read back
		timed = 1'b1;
		for (int i = 0; i < 8; i++) begin
			data = 8'($urandom);
			run_request(1'b0, op_io_write, port_addr(2'd0), data);
			run_request(1'b0, op_io_read, port_addr(2'd0), 8'h00);
			data = 8'($urandom);
			run_request(1'b0, op_io_write, port_addr(2'd2), data);
			run_request(1'b0, op_io_read, port_addr(2'd2), 8'h00);
		end

		// key events followed by every row through port B and then port D
		for (int i = 0; i < 40; i++) begin
			send_key(4'($urandom_range(0, 15)), 3'($urandom_range(0, 7)),
				1'($urandom_range(0, 1)));
		end
		for (int r = 0; r < 16; r++) begin
			run_request(1'b0, op_io_write, port_addr(2'd2), {4'($urandom_range(0, 15)), 4'(r)});
			run_request(1'b0, op_io_read, port_addr(2'd1), 8'h00);
		end
		run_request(1'b0, op_io_write, port_addr(2'd3), 8'($urandom));
		run_request(1'b0, op_io_read, port_addr(2'd3), 8'h00);

		// cycles that nobody answers
		for (int i = 0; i < 6; i++) begin
			address = {8'h00, 8'($urandom_range(0, 8'hA7))};
			run_request(1'b0, op_io_read, address, 8'h00);
			run_request(1'b0, op_io_write, address, 8'($urandom));
			address = 16'($urandom);
			run_request(1'b0, op_mem_read, address, 8'h00);
		end
		run_request(1'b0, op_mem_write, port_addr(2'd0), 8'h5A);
		run_request(1'b0, op_mem_read, port_addr(2'd0), 8'h00);
		run_request(1'b0, op_io_read, 16'h00AC, 8'h00);
		timed = 1'b0;

		// both masters at random
		fork
			random_requests(1'b0, 40);
			random_requests(1'b1, 40);
		join

		repeat (4) @(negedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

// File: hw/msx_io_top.sv
// cpu and debug masters share the io bus; only the PPI answers, memory cycles read FFh
`include "msx_bus_defs.svh"

module msx_io_top (
	input  logic                       clk,
	input  logic                       n_reset,
	// cpu master
	input  logic                       cpu_req,
	input  msx_bus_pkg::bus_op_e       cpu_op,
	input  logic [`MSX_BUS_ADDR_W-1:0] cpu_address,
	input  logic [`MSX_BUS_DATA_W-1:0] cpu_write_data,
	output logic                       cpu_done,
	output logic [`MSX_BUS_DATA_W-1:0] cpu_read_data,
	// debug master
	input  logic                       dbg_req,
	input  msx_bus_pkg::bus_op_e       dbg_op,
	input  logic [`MSX_BUS_ADDR_W-1:0] dbg_address,
	input  logic [`MSX_BUS_DATA_W-1:0] dbg_write_data,
	output logic                       dbg_done,
	output logic [`MSX_BUS_DATA_W-1:0] dbg_read_data,
	// keyboard events
	input  logic                       key_valid,
	input  logic [3:0]                 key_event_row,
	input  logic [2:0]                 key_col,
	input  logic                       key_pressed,
	// PPI outputs
	output logic [`MSX_BUS_DATA_W-1:0] primary_slot,
	output logic [3:0]                 key_row,
	output logic                       motor_off,
	output logic                       cas_write,
	output logic                       caps_led_off,
	output logic                       click_sound
);

	// selected row byte from the matrix into port B
	logic [7:0] key_column;

	// ----------------------------------------------------------
	// bus and masters
	// ----------------------------------------------------------
	msx_bus_if bus_i ();

	bus_arbiter arbiter_i (
		.clk            (clk),
		.n_reset        (n_reset),
		.cpu_req        (cpu_req),
		.cpu_op         (cpu_op),
		.cpu_address    (cpu_address),
		.cpu_write_data (cpu_write_data),
		.cpu_done       (cpu_done),
		.cpu_read_data  (cpu_read_data),
		.dbg_req        (dbg_req),
		.dbg_op         (dbg_op),
		.dbg_address    (dbg_address),
		.dbg_write_data (dbg_write_data),
		.dbg_done       (dbg_done),
		.dbg_read_data  (dbg_read_data),
		.bus            (bus_i.master)
	);

	// ----------------------------------------------------------
	// devices
	// ----------------------------------------------------------
	ppi ppi_i (
		.clk          (clk),
		.n_reset      (n_reset),
		.bus          (bus_i.device),
		.primary_slot (primary_slot),
		.key_row      (key_row),
		.motor_off    (motor_off),
		.cas_write    (cas_write),
		.caps_led_off (caps_led_off),
		.click_sound  (click_sound),
		.key_column   (key_column)
	);

	// row select also leaves the top
	key_matrix key_matrix_i (
		.clk           (clk),
		.n_reset       (n_reset),
		.key_valid     (key_valid),
		.key_event_row (key_event_row),
		.key_col       (key_col),
		.key_pressed   (key_pressed),
		.key_row       (key_row),
		.key_column    (key_column)
	);

endmodule

// File: ppi/ppi.sv
// PPI in mode 0 only, io ports A8h to ABh decoded from address bits 7:2
`include "msx_bus_defs.svh"

module ppi (
	input  logic                       clk,
	input  logic                       n_reset,
	msx_bus_if.device                  bus,
	output logic [`MSX_BUS_DATA_W-1:0] primary_slot,
	output logic [3:0]                 key_row,
	output logic                       motor_off,
	output logic                       cas_write,
	output logic                       caps_led_off,
	output logic                       click_sound,
	input  logic [`MSX_BUS_DATA_W-1:0] key_column
);
	import msx_dev_pkg::*;

	localparam logic [7:0] ppi_base = `MSX_PPI_BASE;

	logic                       w_hit;
	logic                       w_read_hit;
	logic                       w_write_hit;
	ppi_port_e                  w_port;
	logic [`MSX_BUS_DATA_W-1:0] w_read_mux;

	logic [`MSX_BUS_DATA_W-1:0] ff_primary_slot;
	ppi_port_c_t                ff_port_c;
	logic                       ff_read_ready;
	ppi_port_e                  ff_read_port;

	// ----------------------------------------------------------
	// decode
	// ----------------------------------------------------------
	// io cycles only, upper address byte ignored
	assign w_hit       = bus.io && (bus.address[7:2] == ppi_base[7:2]);
	assign w_read_hit  = w_hit && bus.read;
	assign w_write_hit = w_hit && bus.write;
	assign w_port      = ppi_port_e'(bus.address[1:0]);

	// ----------------------------------------------------------
	// write registers
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_primary_slot <= '0;
			// row F selects nothing, motor stopped, LED off
			ff_port_c <= '{click_sound: 1'b0, caps_led_off: 1'b1,
				cas_write: 1'b1, motor_off: 1'b1, key_row: 4'hF};
		end else if (w_write_hit) begin
			case (w_port)
				port_a:  ff_primary_slot <= bus.write_data;
				port_c:  ff_port_c       <= ppi_port_c_t'(bus.write_data);
				// port B is input only, port D ignores writes
				default: ;
			endcase
		end
	end

	assign primary_slot = ff_primary_slot;
	assign key_row      = ff_port_c.key_row;
	assign motor_off    = ff_port_c.motor_off;
	assign cas_write    = ff_port_c.cas_write;
	assign caps_led_off = ff_port_c.caps_led_off;
	assign click_sound  = ff_port_c.click_sound;

	// ----------------------------------------------------------
	// read response
	// ----------------------------------------------------------
	// answer exactly one cycle after the strobe
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
		end else begin
			ff_read_ready <= w_read_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (w_read_hit) begin
			ff_read_port <= w_port;
		end
	end

	// port B reads the current row, so a row change shows on the next read
	always_comb begin
		case (ff_read_port)
			port_a:  w_read_mux = ff_primary_slot;
			port_b:  w_read_mux = key_column;
			port_c:  w_read_mux = ff_port_c;
			default: w_read_mux = {`MSX_BUS_DATA_W{1'b1}};
		endcase
	end

	// bus data stays 00h between answers
	assign bus.read_data  = ff_read_ready ? w_read_mux : '0;
	assign bus.read_ready = ff_read_ready;

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_ready_after_read: assert property (@(posedge clk) disable iff (!n_reset)
		bus.read_ready |-> $past(w_read_hit));

endmodule

// File: ppi/key_matrix.sv
// MSX_KEY_ROWS rows of 8 keys, active low; events and reads for missing rows are ignored
`include "msx_bus_defs.svh"

module key_matrix (
	input  logic       clk,
	input  logic       n_reset,
	// key event from the host
	input  logic       key_valid,
	input  logic [3:0] key_event_row,
	input  logic [2:0] key_col,
	input  logic       key_pressed,
	// row select from PPI port C
	input  logic [3:0] key_row,
	output logic [7:0] key_column
);

	// one byte per row, bit 0 while the key is held
	logic [7:0] ff_keys [`MSX_KEY_ROWS];

	logic       w_event_ok;
	logic       w_row_ok;

	// ----------------------------------------------------------
	// key events
	// ----------------------------------------------------------
	// row 11 and up have no key lines
	assign w_event_ok = key_valid && (key_event_row < 4'(`MSX_KEY_ROWS));

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			// every key released
			for (int r = 0; r < `MSX_KEY_ROWS; r++) begin
				ff_keys[r] <= 8'hFF;
			end
		end else if (w_event_ok) begin
			// pressed drives the line low
			ff_keys[key_event_row][key_col] <= !key_pressed;
		end
	end

	// ----------------------------------------------------------
	// row read
	// ----------------------------------------------------------
	assign w_row_ok = (key_row < 4'(`MSX_KEY_ROWS));

	// missing rows float high like an open key line
	assign key_column = w_row_ok ? ff_keys[key_row] : 8'hFF;

endmodule

// File: hw/bus_arbiter.sv
// one transaction at a time; unanswered reads end after MSX_BUS_READ_WAIT cycles with FFh
`include "msx_bus_defs.svh"

module bus_arbiter (
	input  logic                       clk,
	input  logic                       n_reset,
	// cpu master
	input  logic                       cpu_req,
	input  msx_bus_pkg::bus_op_e       cpu_op,
	input  logic [`MSX_BUS_ADDR_W-1:0] cpu_address,
	input  logic [`MSX_BUS_DATA_W-1:0] cpu_write_data,
	output logic                       cpu_done,
	output logic [`MSX_BUS_DATA_W-1:0] cpu_read_data,
	// debug master
	input  logic                       dbg_req,
	input  msx_bus_pkg::bus_op_e       dbg_op,
	input  logic [`MSX_BUS_ADDR_W-1:0] dbg_address,
	input  logic [`MSX_BUS_DATA_W-1:0] dbg_write_data,
	output logic                       dbg_done,
	output logic [`MSX_BUS_DATA_W-1:0] dbg_read_data,
	// shared bus
	msx_bus_if.master                  bus
);
	import msx_bus_pkg::*;

	localparam int wait_w = $clog2(`MSX_BUS_READ_WAIT + 1);

	arb_state_e                 ff_state;
	// 1 when the cpu had the last grant
	logic                       ff_last_cpu;
	logic                       ff_grant_dbg;
	bus_op_e                    ff_op;
	logic [`MSX_BUS_ADDR_W-1:0] ff_address;
	logic [`MSX_BUS_DATA_W-1:0] ff_write_data;
	logic [wait_w-1:0]          ff_wait;

	logic                       w_pick_dbg;
	logic                       w_strobe;
	logic                       w_is_read;
	logic                       w_timeout;
	logic                       w_done;
	logic [`MSX_BUS_DATA_W-1:0] w_read_data;

	// ----------------------------------------------------------
	// round robin pick
	// ----------------------------------------------------------
	// debug wins when alone, or when both ask and the cpu went last
	assign w_pick_dbg = dbg_req && (!cpu_req || ff_last_cpu);

	// ----------------------------------------------------------
	// FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_state     <= arb_idle;
			ff_last_cpu  <= 1'b0;
			ff_grant_dbg <= 1'b0;
			ff_wait      <= '0;
		end else begin
			case (ff_state)
				arb_idle: begin
					if (cpu_req || dbg_req) begin
						ff_state     <= arb_issue;
						ff_grant_dbg <= w_pick_dbg;
						ff_last_cpu  <= !w_pick_dbg;
					end
				end
				arb_issue: begin
					// first wait cycle is one cycle after the strobe
					ff_state <= arb_wait;
					ff_wait  <= wait_w'(1);
				end
				arb_wait: begin
					if (w_done) begin
						ff_state <= arb_idle;
					end else begin
						ff_wait <= ff_wait + 1'b1;
					end
				end
				default: begin
					ff_state <= arb_idle;
				end
			endcase
		end
	end

	// request is captured while idle, held for the whole transaction
	always_ff @(posedge clk) begin
		if (ff_state == arb_idle) begin
			ff_op         <= w_pick_dbg ? dbg_op : cpu_op;
			ff_address    <= w_pick_dbg ? dbg_address : cpu_address;
			ff_write_data <= w_pick_dbg ? dbg_write_data : cpu_write_data;
		end
	end

	// ----------------------------------------------------------
	// bus drive
	// ----------------------------------------------------------
	assign w_strobe  = (ff_state == arb_issue);
	assign w_is_read = (ff_op == op_io_read) || (ff_op == op_mem_read);

	assign bus.read       = w_strobe && w_is_read;
	assign bus.write      = w_strobe && !w_is_read;
	assign bus.io         = w_strobe && ((ff_op == op_io_read) || (ff_op == op_io_write));
	assign bus.memory     = w_strobe && ((ff_op == op_mem_read) || (ff_op == op_mem_write));
	assign bus.address    = ff_address;
	assign bus.write_data = ff_write_data;

	// ----------------------------------------------------------
	// completion
	// ----------------------------------------------------------
	assign w_timeout = (ff_wait == wait_w'(`MSX_BUS_READ_WAIT));
	// writes finish in the first wait cycle
	assign w_done    = (ff_state == arb_wait) && (!w_is_read || bus.read_ready || w_timeout);
	// nobody answered, the floating bus reads FFh
	assign w_read_data = bus.read_ready ? bus.read_data : {`MSX_BUS_DATA_W{1'b1}};

	// done and data reach the granted master only
	assign cpu_done      = w_done && !ff_grant_dbg;
	assign dbg_done      = w_done && ff_grant_dbg;
	assign cpu_read_data = cpu_done ? w_read_data : '0;
	assign dbg_read_data = dbg_done ? w_read_data : '0;

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_single_strobe: assert property (@(posedge clk) disable iff (!n_reset)
		!(bus.read && bus.write));

	// a device answer outside the wait state would be lost
	a_ready_in_wait: assert property (@(posedge clk) disable iff (!n_reset)
		bus.read_ready |-> (ff_state == arb_wait));

endmodule

// File: common/msx_bus_if.sv
// one shared bus, single outstanding read, at most one strobe per cycle
`include "msx_bus_defs.svh"

interface msx_bus_if;

	// address and write data are valid in the strobe cycle
	logic [`MSX_BUS_ADDR_W-1:0] address;
	logic [`MSX_BUS_DATA_W-1:0] write_data;
	// one cycle strobes
	logic                       read;
	logic                       write;
	// cycle qualifiers, valid with the strobe
	logic                       io;
	logic                       memory;
	// read response from the answering device
	logic                       read_ready;
	logic [`MSX_BUS_DATA_W-1:0] read_data;

	// ----------------------------------------------------------
	// views
	// ----------------------------------------------------------
	modport master (
		output address,
		output write_data,
		output read,
		output write,
		output io,
		output memory,
		input  read_ready,
		input  read_data
	);

	modport device (
		input  address,
		input  write_data,
		input  read,
		input  write,
		input  io,
		input  memory,
		output read_ready,
		output read_data
	);

endinterface

// File: common/msx_dev_pkg.sv
// PPI port and port C layout; mode control word and modes 1 and 2 are not modeled
package msx_dev_pkg;

	// port selected by address bits 1:0
	typedef enum logic [1:0] {
		port_a,
		port_b,
		port_c,
		port_d
	} ppi_port_e;

	// ----------------------------------------------------------
	// port C register, top bit first
	// ----------------------------------------------------------
	typedef struct packed {
		// keyboard click, 1 sounds
		logic       click_sound;
		// caps lock LED, active low
		logic       caps_led_off;
		// cassette output bit
		logic       cas_write;
		// cassette motor, 1 stops it
		logic       motor_off;
		// keyboard row select
		logic [3:0] key_row;
	} ppi_port_c_t;

endpackage

// File: common/msx_bus_pkg.sv
// bus opcode and arbiter state types; memory opcodes exist but no memory device answers
package msx_bus_pkg;

	// ----------------------------------------------------------
	// master request opcode
	// ----------------------------------------------------------
	// io opcodes set the io qualifier, mem opcodes set the memory qualifier
	typedef enum logic [1:0] {
		op_io_read,
		op_io_write,
		op_mem_read,
		op_mem_write
	} bus_op_e;

	// ----------------------------------------------------------
	// arbiter FSM
	// ----------------------------------------------------------
	// idle   waits for a request and picks a master
	// issue  drives the single strobe cycle
	// wait   ends a write at once, a read on read_ready or timeout
	typedef enum logic [1:0] {
		arb_idle,
		arb_issue,
		arb_wait
	} arb_state_e;

endpackage

// File: common/msx_bus_defs.svh
// bus widths and PPI limits; the PPI base must keep its low two bits zero
`ifndef MSX_BUS_DEFS_SVH
`define MSX_BUS_DEFS_SVH

// ----------------------------------------------------------
// bus widths
// ----------------------------------------------------------
// full 16 bit address, io devices decode the low byte only
`define MSX_BUS_ADDR_W 16
`define MSX_BUS_DATA_W 8

// ----------------------------------------------------------
// devices and timing
// ----------------------------------------------------------
// PPI occupies A8h to ABh
`define MSX_PPI_BASE 8'hA8
// rows 0 to 10 exist, higher rows read as no key line
`define MSX_KEY_ROWS 11
// cycles after the read strobe before an unanswered read ends with FFh
`define MSX_BUS_READ_WAIT 4

`endif
